// ==== include/div_params.svh ====
// divider widths; the design only supports 32-bit operands and one quotient bit per cycle
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// operand and result width in bits
// other values are not supported by the RV32 M encoding
`define DIV_XLEN 32

// restoring divider iterations
// one quotient bit per core cycle, equal to the operand width
`define DIV_ITERS 32

`endif

// ==== hw/div_pkg.sv ====
// shared divider types; needs div_params.svh on the include path, widths fixed by DIV_XLEN
`include "div_params.svh"

package div_pkg;

	// bit 1 selects signed, bit 0 selects remainder
	typedef enum logic [1:0] {
		DIVU = 2'd0,
		REMU = 2'd1,
		DIV  = 2'd2,
		REM  = 2'd3
	} div_op_e;

	// iterative core states
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		RUN  = 2'd1,
		DONE = 2'd2
	} div_state_e;

	typedef struct packed {
		div_op_e             op;
		logic [`DIV_XLEN-1:0] dividend;
		logic [`DIV_XLEN-1:0] divisor;
	} div_req_t;

	// operands after sign handling, ready for the unsigned core
	typedef struct packed {
		div_op_e             op;
		logic [`DIV_XLEN-1:0] dividend_mag;
		logic [`DIV_XLEN-1:0] divisor_mag;
		logic                neg_quot;
		logic                neg_rem;
		logic                div_zero;
		logic [`DIV_XLEN-1:0] dividend;
	} div_job_t;

	// unsigned core results plus the flags needed to fix signs
	typedef struct packed {
		div_op_e             op;
		logic [`DIV_XLEN-1:0] quot;
		logic [`DIV_XLEN-1:0] rem;
		logic                neg_quot;
		logic                neg_rem;
		logic                div_zero;
		logic [`DIV_XLEN-1:0] dividend;
	} div_raw_t;

	typedef struct packed {
		logic [`DIV_XLEN-1:0] result;
	} div_rsp_t;

endpackage

// ==== hw/div_operand_prep.sv ====
// request stage; holds one job, req_i must stay stable while valid is high and ready is low
`include "div_params.svh"

module div_operand_prep (
	input  logic                clk_i,
	input  logic                rst_i,

	// request side
	input  logic                req_valid_i,
	output logic                req_ready_o,
	input  div_pkg::div_req_t   req_i,

	// to the iterative core
	output logic                job_valid_o,
	input  logic                job_ready_i,
	output div_pkg::div_job_t   job_o
);

	logic                 job_valid_q;
	div_pkg::div_job_t    job_q;
	div_pkg::div_job_t    job_d;

	logic                 req_take;
	logic                 is_signed;
	logic                 dvd_neg;
	logic                 dvs_neg;

	// slot is free when empty or drained this cycle
	assign req_ready_o = !job_valid_q || job_ready_i;
	assign req_take    = req_valid_i && req_ready_o;

	assign is_signed = req_i.op[1];
	assign dvd_neg   = is_signed && req_i.dividend[`DIV_XLEN-1];
	assign dvs_neg   = is_signed && req_i.divisor[`DIV_XLEN-1];

	always_comb begin
		job_d.op       = req_i.op;
		job_d.dividend = req_i.dividend;

		// two's complement magnitude, most negative value maps to 2^31 unsigned
		if (dvd_neg) begin
			job_d.dividend_mag = -req_i.dividend;
		end else begin
			job_d.dividend_mag = req_i.dividend;
		end

		if (dvs_neg) begin
			job_d.divisor_mag = -req_i.divisor;
		end else begin
			job_d.divisor_mag = req_i.divisor;
		end

		// sign rules decided once here
		job_d.neg_quot = dvd_neg ^ dvs_neg;
		job_d.neg_rem  = dvd_neg;
		job_d.div_zero = (req_i.divisor == '0);
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			job_valid_q <= 1'b0;
		end else if (req_take) begin
			job_valid_q <= 1'b1;
		end else if (job_ready_i) begin
			job_valid_q <= 1'b0;
		end
	end

	// payload only
	always_ff @(posedge clk_i) begin
		if (req_take) begin
			job_q <= job_d;
		end
	end

	assign job_valid_o = job_valid_q;
	assign job_o       = job_q;

endmodule

// ==== hw/div_iter_core.sv ====
// restoring divider over magnitudes, fixed DIV_ITERS run cycles per job, no early exit
`include "div_params.svh"

module div_iter_core (
	input  logic                clk_i,
	input  logic                rst_i,

	// from operand prep
	input  logic                job_valid_i,
	output logic                job_ready_o,
	input  div_pkg::div_job_t   job_i,

	// to result fix
	output logic                raw_valid_o,
	input  logic                raw_ready_i,
	output div_pkg::div_raw_t   raw_o
);

	localparam int unsigned CNT_W = $clog2(`DIV_ITERS + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`DIV_ITERS - 1);
	localparam logic [CNT_W-1:0] CNT_MAX  = CNT_W'(`DIV_ITERS);

	div_pkg::div_state_e  state_q;
	logic [CNT_W-1:0]     cnt_q;

	// job copy for flags, op, original dividend and divisor
	div_pkg::div_job_t    job_q;

	// partial remainder, one bit wider than the operands
	logic [`DIV_XLEN:0]   pr_q;
	// dividend bits leave at the top, quotient bits enter at the bottom
	logic [`DIV_XLEN-1:0] quot_q;

	logic [`DIV_XLEN:0]   pr_shift;
	logic [`DIV_XLEN:0]   pr_diff;
	logic                 job_take;

	assign job_ready_o = (state_q == div_pkg::IDLE) ||
		((state_q == div_pkg::DONE) && raw_ready_i);
	assign job_take = job_valid_i && job_ready_o;

	// next dividend bit shifted in, then trial subtract
	assign pr_shift = {pr_q[`DIV_XLEN-1:0], quot_q[`DIV_XLEN-1]};
	assign pr_diff  = pr_shift - {1'b0, job_q.divisor_mag};

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state_q <= div_pkg::IDLE;
			cnt_q   <= '0;
		end else begin
			case (state_q)
				div_pkg::IDLE: begin
					if (job_take) begin
						state_q <= div_pkg::RUN;
					end
				end
				div_pkg::RUN: begin
					if (cnt_q == CNT_LAST) begin
						state_q <= div_pkg::DONE;
					end
				end
				div_pkg::DONE: begin
					// back-to-back job starts straight from DONE
					if (job_take) begin
						state_q <= div_pkg::RUN;
					end else if (raw_ready_i) begin
						state_q <= div_pkg::IDLE;
					end
				end
				default: begin
					state_q <= div_pkg::IDLE;
				end
			endcase

			if (job_take) begin
				cnt_q <= '0;
			end else if (state_q == div_pkg::RUN) begin
				cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (job_take) begin
			job_q  <= job_i;
			pr_q   <= '0;
			quot_q <= job_i.dividend_mag;
		end else if (state_q == div_pkg::RUN) begin
			if (!pr_diff[`DIV_XLEN]) begin
				pr_q   <= pr_diff;
				quot_q <= {quot_q[`DIV_XLEN-2:0], 1'b1};
			end else begin
				// restore
				pr_q   <= pr_shift;
				quot_q <= {quot_q[`DIV_XLEN-2:0], 1'b0};
			end
		end
	end

	assign raw_valid_o = (state_q == div_pkg::DONE);

	always_comb begin
		raw_o.op       = job_q.op;
		raw_o.quot     = quot_q;
		raw_o.rem      = pr_q[`DIV_XLEN-1:0];
		raw_o.neg_quot = job_q.neg_quot;
		raw_o.neg_rem  = job_q.neg_rem;
		raw_o.div_zero = job_q.div_zero;
		raw_o.dividend = job_q.dividend;
	end

	// a new job lands only when idle or after all iterations have run
	a_job_accept_state: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(job_valid_i && job_ready_o) |->
			((state_q == div_pkg::IDLE) || (cnt_q == CNT_MAX))
	) else $error("div_iter_core: job accepted before the iterations finished");

	a_cnt_range: assert property (
		@(posedge clk_i) disable iff (rst_i)
		cnt_q <= CNT_MAX
	) else $error("div_iter_core: iteration counter out of range");

endmodule

// ==== hw/div_result_fix.sv ====
// output stage; applies RISC-V sign and zero-divisor rules and holds rsp_o under back-pressure
`include "div_params.svh"

module div_result_fix (
	input  logic                clk_i,
	input  logic                rst_i,

	// from the iterative core
	input  logic                raw_valid_i,
	output logic                raw_ready_o,
	input  div_pkg::div_raw_t   raw_i,

	// response side
	output logic                rsp_valid_o,
	input  logic                rsp_ready_i,
	output div_pkg::div_rsp_t   rsp_o
);

	logic                 rsp_valid_q;
	div_pkg::div_rsp_t    rsp_q;

	logic                 raw_take;
	logic [`DIV_XLEN-1:0] quot_s;
	logic [`DIV_XLEN-1:0] rem_s;
	logic [`DIV_XLEN-1:0] result_d;

	assign raw_ready_o = !rsp_valid_q || rsp_ready_i;
	assign raw_take    = raw_valid_i && raw_ready_o;

	// overflow comes out right here, 2^31 negated stays the most negative value
	assign quot_s = raw_i.neg_quot ? -raw_i.quot : raw_i.quot;
	assign rem_s  = raw_i.neg_rem ? -raw_i.rem : raw_i.rem;

	always_comb begin
		if (raw_i.div_zero) begin
			// all ones quotient, remainder is the untouched dividend
			if (raw_i.op[0]) begin
				result_d = raw_i.dividend;
			end else begin
				result_d = '1;
			end
		end else if (raw_i.op[0]) begin
			result_d = rem_s;
		end else begin
			result_d = quot_s;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			rsp_valid_q <= 1'b0;
		end else if (raw_take) begin
			rsp_valid_q <= 1'b1;
		end else if (rsp_ready_i) begin
			rsp_valid_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_i) begin
		if (raw_take) begin
			rsp_q.result <= result_d;
		end
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = rsp_q;

	// stalled response keeps both valid and data
	a_rsp_hold: assert property (
		@(posedge clk_i) disable iff (rst_i)
		(rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o))
	) else $error("div_result_fix: response changed during stall");

endmodule

// ==== hw/div_unit_top.sv ====
// divide unit top; three stages, 34 cycle latency without back-pressure, no flush support
module div_unit_top (
	input  logic                clk_i,
	input  logic                rst_i,

	// request side
	input  logic                req_valid_i,
	output logic                req_ready_o,
	input  div_pkg::div_req_t   req_i,

	// response side
	output logic                rsp_valid_o,
	input  logic                rsp_ready_i,
	output div_pkg::div_rsp_t   rsp_o
);

	// prep to core
	logic                 job_valid;
	logic                 job_ready;
	div_pkg::div_job_t    job;

	// core to fix
	logic                 raw_valid;
	logic                 raw_ready;
	div_pkg::div_raw_t    raw;

	div_operand_prep i_prep (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_i       (req_i),
		.job_valid_o (job_valid),
		.job_ready_i (job_ready),
		.job_o       (job)
	);

	div_iter_core i_core (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.job_valid_i (job_valid),
		.job_ready_o (job_ready),
		.job_i       (job),
		.raw_valid_o (raw_valid),
		.raw_ready_i (raw_ready),
		.raw_o       (raw)
	);

	div_result_fix i_fix (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.raw_valid_i (raw_valid),
		.raw_ready_o (raw_ready),
		.raw_i       (raw),
		.rsp_valid_o (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_o       (rsp_o)
	);

endmodule

// ==== tb/tb_div_unit.sv ====
// divide unit regression from a fixed LFSR seed; expects 32-bit operands and stops at the first error
`include "div_params.svh"

module tb_div_unit;

	localparam int NUM_TESTS  = 400;
	localparam int NUM_DIRECT = 8;
	localparam int CLK_PERIOD = 4;
	localparam int LATENCY    = 34;
	localparam int MARGIN_CYC = 1000;

	logic                 clk_i;
	logic                 rst_i;
	logic                 req_valid_i;
	logic                 req_ready_o;
	div_pkg::div_req_t    req_i;
	logic                 rsp_valid_o;
	logic                 rsp_ready_i;
	div_pkg::div_rsp_t    rsp_o;

	logic [31:0]          lfsr_q;
	div_pkg::div_rsp_t    exp_q[$];
	div_pkg::div_req_t    sent_q[$];
	int                   rsp_count;
	int                   n_sent;
	int                   gap;
	int                   max_depth;
	logic                 req_fired;
	logic                 hold_pending;
	div_pkg::div_rsp_t    held_rsp;

	div_unit_top i_dut (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.req_valid_i (req_valid_i),
		.req_ready_o (req_ready_o),
		.req_i       (req_i),
		.rsp_valid_o (rsp_valid_o),
		.rsp_ready_i (rsp_ready_i),
		.rsp_o       (rsp_o)
	);

	initial begin
		clk_i = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) clk_i = ~clk_i;
		end
	end

	// galois lfsr, taps 32 22 2 1
	function logic lfsr_bit();
		logic out;
		out    = lfsr_q[0];
		lfsr_q = {1'b0, lfsr_q[31:1]} ^ (out ? 32'h8020_0003 : 32'h0);
		return out;
	endfunction

	function logic [31:0] draw_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	// biased toward zero, minus one and the most negative value
	function logic [`DIV_XLEN-1:0] draw_operand();
		logic [2:0]           sel;
		logic [`DIV_XLEN-1:0] v;
		sel = 3'(draw_bits(3));
		case (sel)
			3'd0: v = '0;
			3'd1: v = 32'hffff_ffff;
			3'd2: v = 32'h8000_0000;
			3'd3: v = draw_bits(4);
			default: v = draw_bits(32);
		endcase
		return v;
	endfunction

	function div_pkg::div_req_t random_req();
		div_pkg::div_req_t r;
		logic [1:0]        op_bits;
		op_bits    = 2'(draw_bits(2));
		r.op       = div_pkg::div_op_e'(op_bits);
		r.dividend = draw_operand();
		r.divisor  = draw_operand();
		return r;
	endfunction

	// zero divisor for all four ops, then overflow, then a small signed case
	function div_pkg::div_req_t directed_req(input int idx);
		div_pkg::div_req_t r;
		r.op       = div_pkg::div_op_e'(idx[1:0]);
		r.dividend = 32'h8765_4321;
		r.divisor  = '0;
		if (idx >= 4) begin
			r.op       = idx[0] ? div_pkg::REM : div_pkg::DIV;
			r.dividend = 32'h8000_0000;
			r.divisor  = 32'hffff_ffff;
		end
		if (idx >= 6) begin
			r.dividend = 32'hffff_fff9;
			r.divisor  = 32'd3;
		end
		return r;
	endfunction

	// RISC-V M rules, truncating toward zero
	function div_pkg::div_rsp_t model_result(input div_pkg::div_req_t r);
		div_pkg::div_rsp_t           e;
		logic signed [`DIV_XLEN-1:0] sa;
		logic signed [`DIV_XLEN-1:0] sb;
		sa = r.dividend;
		sb = r.divisor;
		if (r.divisor == '0) begin
			e.result = r.op[0] ? r.dividend : 32'hffff_ffff;
		end else if (!r.op[1]) begin
			e.result = r.op[0] ? r.dividend % r.divisor : r.dividend / r.divisor;
		end else if (r.dividend == 32'h8000_0000 && r.divisor == 32'hffff_ffff) begin
			e.result = r.op[0] ? 32'h0 : 32'h8000_0000;
		end else begin
			e.result = r.op[0] ? sa % sb : sa / sb;
		end
		return e;
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "stopped after the first failure");
	endtask

	task automatic check_rsp(input div_pkg::div_rsp_t got, input div_pkg::div_rsp_t exp,
			input div_pkg::div_req_t req);
		if (got !== exp) begin
			stop_run($sformatf("error: time %0t: op %0d a %h b %h got %h expected %h",
				$time, req.op, req.dividend, req.divisor, got.result, exp.result));
		end
	endtask

	task automatic check_hold(input div_pkg::div_rsp_t held, input div_pkg::div_rsp_t now);
		if (now !== held) begin
			stop_run($sformatf("error: time %0t: stalled response changed from %h to %h",
				$time, held.result, now.result));
		end
	endtask

	// sampled at the rising edge, before any register update
	always @(posedge clk_i) begin
		if (!rst_i) begin
			if (hold_pending) begin
				if (!rsp_valid_o) begin
					stop_run($sformatf("error: time %0t: rsp_valid_o dropped during a stall",
						$time));
				end
				check_hold(held_rsp, rsp_o);
			end
			hold_pending = rsp_valid_o && !rsp_ready_i;
			held_rsp     = rsp_o;

			req_fired = req_valid_i && req_ready_o;
			if (req_fired) begin
				exp_q.push_back(model_result(req_i));
				sent_q.push_back(req_i);
				if (exp_q.size() > max_depth) begin
					max_depth = exp_q.size();
				end
			end

			if (rsp_valid_o && rsp_ready_i) begin
				if (exp_q.size() == 0) begin
					stop_run("a response arrived while no request was outstanding");
				end else begin
					check_rsp(rsp_o, exp_q.pop_front(), sent_q.pop_front());
					rsp_count++;
				end
			end
		end
	end

	initial begin
		#((NUM_TESTS * LATENCY + MARGIN_CYC) * CLK_PERIOD);
		$display("timeout: responses stopped arriving, %0d of %0d received",
			rsp_count, NUM_TESTS);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst_i        = 1'b1;
		req_valid_i  = 1'b0;
		req_i        = '0;
		rsp_ready_i  = 1'b0;
		lfsr_q       = 32'h1ec2b098;
		rsp_count    = 0;
		n_sent       = 0;
		gap          = 0;
		max_depth    = 0;
		req_fired    = 1'b0;
		hold_pending = 1'b0;
		held_rsp     = '0;

		repeat (5) @(posedge clk_i);
		@(negedge clk_i);
		rst_i = 1'b0;

		@(posedge clk_i);
		if (req_ready_o !== 1'b1 || rsp_valid_o !== 1'b0) begin
			stop_run($sformatf("error: time %0t: idle state after reset is wrong", $time));
		end

		// directed burst goes back-to-back, random part adds gaps and stalls
		while (n_sent < NUM_TESTS || req_valid_i) begin
			@(negedge clk_i);
			if (n_sent < NUM_DIRECT) begin
				rsp_ready_i = 1'b1;
			end else begin
				rsp_ready_i = (draw_bits(2) != 0);
			end
			if (req_fired) begin
				req_valid_i = 1'b0;
				if (n_sent >= NUM_DIRECT && draw_bits(1) != 0) begin
					gap = int'(draw_bits(2));
				end
			end
			if (!req_valid_i && n_sent < NUM_TESTS) begin
				if (gap > 0) begin
					gap--;
				end else begin
					req_i       = (n_sent < NUM_DIRECT) ? directed_req(n_sent) : random_req();
					req_valid_i = 1'b1;
					n_sent++;
				end
			end
		end

		// drain without stalls, the last job runs at most one core pass behind another
		@(negedge clk_i);
		rsp_ready_i = 1'b1;
		repeat (2 * LATENCY) @(posedge clk_i);
		@(negedge clk_i);

		if (exp_q.size() != 0) begin
			stop_run($sformatf("%0d expected responses never arrived", exp_q.size()));
		end else if (max_depth < 3) begin
			stop_run("back-to-back requests never filled all three stages");
		end else begin
			$display("TB PASSED");
			$finish;
		end
	end

endmodule

// ==== files.f ====
+incdir+include
hw/div_pkg.sv
hw/div_operand_prep.sv
hw/div_iter_core.sv
hw/div_result_fix.sv
hw/div_unit_top.sv
tb/tb_div_unit.sv
